//--- test/lce_cmd_vectors.txt
# cmd addr src way state wdata exp_resp exp_dst exp_word (all hex)
# cmd 0 sync 1 set_clear 2 inv 3 st 4 data 5 st_wakeup 6 wb 7 st_wb; exp_resp 7 is none
0 0000000000 1 0 0 00000000 0 1 00000000
0 0000000000 2 0 0 00000000 0 2 00000000
4 00000ab040 1 2 3 a5a50001 2 1 00000000
4 0000123080 2 5 2 5a5a0002 2 2 00000000
5 00000ab040 1 2 1 00000000 2 1 00000000
6 00000ab040 1 2 1 00000000 3 1 a5a50001
6 00000ab040 1 2 1 00000000 4 1 00000000
7 0000123080 2 5 1 00000000 3 2 5a5a0002
3 00000000c0 1 0 4 00000000 7 0 00000000
2 00000000c0 1 0 0 00000000 1 1 00000000
4 0000fff100 1 7 3 cafe0004 2 1 00000000
1 0000fff100 1 0 0 00000000 7 0 00000000
6 0000fff100 1 7 0 00000000 4 1 00000000
4 0000777fc0 2 0 4 beef003f 2 2 00000000
7 0000777fc0 2 0 5 00000000 3 2 beef003f
7 0000777fc0 2 0 1 00000000 4 2 00000000
6 0000000280 1 3 0 00000000 4 1 00000000

//--- tb.f
hw/lce_pkg.sv
hw/lce_cmd_decode.sv
hw/lce_read_capture.sv
hw/lce_cmd_ctrl.sv
hw/lce_cmd_top.sv
test/lce_cache_model.sv
test/tb_lce_cmd.sv

//--- Bender.yml
package:
  name: lce_cmd

sources:
  - hw/lce_pkg.sv
  - hw/lce_cmd_decode.sv
  - hw/lce_read_capture.sv
  - hw/lce_cmd_ctrl.sv
  - hw/lce_cmd_top.sv
  - target: test
    files:
      - test/lce_cache_model.sv
      - test/tb_lce_cmd.sv

//--- test/tb_lce_cmd.sv
module tb_lce_cmd;
  timeunit 1ns;
  timeprecision 1ps;
  import lce_pkg::*;

  localparam int sets_lp = 64;
  localparam lce_id_t own_id_lp = 4'h3;

  logic clk_i, reset_i, ready_o, cmd_v_i, cmd_yumi_o, resp_v_o, resp_yumi_i;
  lce_id_t lce_id_i, cmd_src_id_i, resp_dst_id_o, resp_src_id_o;
  lce_cmd_e cmd_type_i;
  paddr_t cmd_addr_i, resp_addr_o;
  way_t cmd_way_i, tag_way_o, data_way_o, stat_way_o;
  coh_state_e cmd_state_i, tag_state_o;
  block_t cmd_data_i, resp_data_o, data_wdata_o, data_rdata_i;
  lce_resp_e resp_type_o;
  logic tag_v_o, tag_yumi_i, data_v_o, data_yumi_i, stat_v_o, stat_yumi_i;
  tag_op_e tag_op_o;
  index_t tag_index_o, data_index_o, stat_index_o;
  tag_t tag_tag_o;
  data_op_e data_op_o;
  stat_op_e stat_op_o;
  dirty_vec_t stat_dirty_i;
  logic cache_req_complete_o, sync_done_o;

  // one entry per vector line
  logic [3:0] v_cmd[$], v_exp_resp[$], v_src[$], v_exp_dst[$];
  logic [39:0] v_addr[$];
  logic [2:0] v_way[$], v_state[$];
  logic [31:0] v_word[$], v_exp_word[$];

  lce_resp_e got_type[$];
  lce_id_t got_dst[$], got_src[$];
  paddr_t got_addr[$];
  block_t got_data[$];
  int completes, errors, cycles, limit, syncs;
  logic [31:0] rng;

  lce_cmd_top #(.sets_p(sets_lp), .num_cce_p(2)) dut0 (.*);

  lce_cache_model model0 (
    .clk_i, .tag_v_i(tag_v_o), .tag_op_i(tag_op_o), .tag_index_i(tag_index_o),
    .tag_way_i(tag_way_o), .tag_state_i(tag_state_o), .tag_tag_i(tag_tag_o),
    .tag_yumi_o(tag_yumi_i), .data_v_i(data_v_o), .data_op_i(data_op_o),
    .data_index_i(data_index_o), .data_way_i(data_way_o), .data_wdata_i(data_wdata_o),
    .data_yumi_o(data_yumi_i), .data_rdata_o(data_rdata_i), .stat_v_i(stat_v_o),
    .stat_op_i(stat_op_o), .stat_index_i(stat_index_o), .stat_way_i(stat_way_o),
    .stat_yumi_o(stat_yumi_i), .stat_dirty_o(stat_dirty_i)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    rng <= xorshift32(rng);
    resp_yumi_i <= rng[7] | rng[3];
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("timeout: run exceeded %0d cycles", limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // responses and completion pulses are sampled mid-cycle
  always @(negedge clk_i) begin
    if (resp_v_o && resp_yumi_i) begin
      got_type.push_back(resp_type_o);
      got_dst.push_back(resp_dst_id_o);
      got_src.push_back(resp_src_id_o);
      got_addr.push_back(resp_addr_o);
      got_data.push_back(resp_data_o);
    end
    if (cache_req_complete_o) begin
      completes++;
    end
  end

  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic load_vectors();
    int fd, n;
    string line;
    logic [3:0] c, r, s, d;
    logic [39:0] a;
    logic [2:0] w, st;
    logic [31:0] wd, ew;
    fd = $fopen("test/lce_cmd_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the vector file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", c, a, s, w, st, wd, r, d, ew);
          if (n == 9) begin
            v_cmd.push_back(c);
            v_addr.push_back(a);
            v_src.push_back(s);
            v_way.push_back(w);
            v_state.push_back(st);
            v_word.push_back(wd);
            v_exp_resp.push_back(r);
            v_exp_dst.push_back(d);
            v_exp_word.push_back(ew);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_vector(input int i);
    index_t idx;
    way_t way;
    lce_cmd_e cmd;
    int exp_n;
    idx = v_addr[i][11:6];
    way = v_way[i];
    cmd = lce_cmd_e'(v_cmd[i]);
    exp_n = (v_exp_resp[i] == 4'h7) ? 0 : 1;
    got_type.delete();
    got_dst.delete();
    got_src.delete();
    got_addr.delete();
    got_data.delete();
    completes = 0;
    @(posedge clk_i);
    cmd_v_i <= 1'b1;
    cmd_type_i <= cmd;
    cmd_addr_i <= v_addr[i];
    cmd_src_id_i <= v_src[i];
    cmd_way_i <= way;
    cmd_state_i <= coh_state_e'(v_state[i]);
    cmd_data_i <= {16{v_word[i]}};
    do @(negedge clk_i); while (!cmd_yumi_o);
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
    @(negedge clk_i);
    check_value($sformatf("response count (vector %0d)", i), got_type.size(), exp_n);
    if (exp_n == 1 && got_type.size() == 1) begin
      check_value("resp_type_o", got_type[0], v_exp_resp[i]);
      check_value("resp_dst_id_o", got_dst[0], v_exp_dst[i]);
      check_value("resp_src_id_o", got_src[0], own_id_lp);
      check_value("resp_addr_o", got_addr[0], v_addr[i]);
      if (v_exp_resp[i] == 4'h3) begin
        check_value("resp_data_o", got_data[0], {16{v_exp_word[i]}});
      end
    end
    check_value("cache_req_complete_o pulses", completes,
                (cmd == e_cmd_data || cmd == e_cmd_st_wakeup) ? 1 : 0);
    if (cmd == e_cmd_sync) begin
      syncs++;
      check_value("sync_done_o", sync_done_o, syncs >= 2);
    end
    if (cmd == e_cmd_set_clear) begin
      check_value("model dirty bits", model0.dirty_mem[idx], 0);
      for (int w = 0; w < 8; w++) begin
        check_value("model tag state", model0.state_mem[idx][w], e_coh_i);
      end
    end
    if (cmd == e_cmd_inv) begin
      check_value("model tag state", model0.state_mem[idx][way], e_coh_i);
    end
    if (cmd == e_cmd_st || cmd == e_cmd_st_wakeup || cmd == e_cmd_data
        || cmd == e_cmd_st_wb) begin
      check_value("model tag state", model0.state_mem[idx][way], v_state[i]);
    end
    if (cmd == e_cmd_data) begin
      check_value("model tag", model0.tag_mem[idx][way], v_addr[i][39:12]);
      check_value("model block", model0.data_mem[idx][way], {16{v_word[i]}});
    end
    if (cmd == e_cmd_wb || cmd == e_cmd_st_wb) begin
      check_value("model dirty bit", model0.dirty_mem[idx][way], 1'b0);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    lce_id_i = own_id_lp;
    cmd_v_i = 1'b0;
    cmd_type_i = e_cmd_sync;
    cmd_addr_i = '0;
    cmd_src_id_i = '0;
    cmd_way_i = '0;
    cmd_state_i = e_coh_i;
    cmd_data_i = '0;
    resp_yumi_i = 1'b0;
    rng = 32'h68f9_4ae6;
    errors = 0;
    cycles = 0;
    syncs = 0;
    completes = 0;
    limit = 0;
    load_vectors();
    limit = 64 + 4 * sets_lp + v_cmd.size() * 40;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    do @(negedge clk_i); while (!ready_o);
    for (int s = 0; s < sets_lp; s++) begin
      if (!model0.cleared[s]) begin
        errors++;
        $display("set %0d was never cleared before ready_o rose", s);
      end
      check_value("model dirty bits after clear", model0.dirty_mem[s], 0);
      for (int w = 0; w < 8; w++) begin
        check_value("model tag state after clear", model0.state_mem[s][w], e_coh_i);
      end
    end
    for (int i = 0; i < v_cmd.size(); i++) begin
      run_vector(i);
    end
    $display("%0d vectors run, %0d errors", v_cmd.size(), errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- test/lce_cache_model.sv
module lce_cache_model (
  input  logic                clk_i,
  input  logic                tag_v_i,
  input  lce_pkg::tag_op_e    tag_op_i,
  input  lce_pkg::index_t     tag_index_i,
  input  lce_pkg::way_t       tag_way_i,
  input  lce_pkg::coh_state_e tag_state_i,
  input  lce_pkg::tag_t       tag_tag_i,
  output logic                tag_yumi_o,
  input  logic                data_v_i,
  input  lce_pkg::data_op_e   data_op_i,
  input  lce_pkg::index_t     data_index_i,
  input  lce_pkg::way_t       data_way_i,
  input  lce_pkg::block_t     data_wdata_i,
  output logic                data_yumi_o,
  output lce_pkg::block_t     data_rdata_o,
  input  logic                stat_v_i,
  input  lce_pkg::stat_op_e   stat_op_i,
  input  lce_pkg::index_t     stat_index_i,
  input  lce_pkg::way_t       stat_way_i,
  output logic                stat_yumi_o,
  output lce_pkg::dirty_vec_t stat_dirty_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import lce_pkg::*;

  coh_state_e state_mem [64][8];
  tag_t       tag_mem [64][8];
  block_t     data_mem [64][8];
  dirty_vec_t dirty_mem [64];
  // sets that saw a tag and status clear of the same set in the same cycle
  logic [63:0] cleared;
  logic [31:0] rng;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // garbage contents so that the initial clear has work to do
  initial begin
    rng = 32'h68f9_4ae6;
    cleared = '0;
    tag_yumi_o = 1'b0;
    data_yumi_o = 1'b0;
    stat_yumi_o = 1'b0;
    data_rdata_o = '0;
    stat_dirty_o = '0;
    for (int s = 0; s < 64; s++) begin
      dirty_mem[s] = dirty_vec_t'(s * 37 + 5);
      for (int w = 0; w < 8; w++) begin
        state_mem[s][w] = coh_state_e'(((s * 8 + w) % 5) + 1);
        tag_mem[s][w] = tag_t'(32'h0ace_0000 + s * 8 + w);
        data_mem[s][w] = {16{32'hd00d_0000 + s * 8 + w}};
      end
    end
  end

  always @(posedge clk_i) begin
    rng <= xorshift32(rng);
    // each yumi is high three cycles out of four
    tag_yumi_o <= |rng[1:0];
    data_yumi_o <= |rng[3:2];
    stat_yumi_o <= |rng[5:4];
    if (tag_v_i && tag_yumi_o) begin
      if (tag_op_i == e_tag_set_clear) begin
        for (int w = 0; w < 8; w++) begin
          state_mem[tag_index_i][w] <= e_coh_i;
        end
      end else begin
        state_mem[tag_index_i][tag_way_i] <= tag_state_i;
        if (tag_op_i == e_tag_set_tag) begin
          tag_mem[tag_index_i][tag_way_i] <= tag_tag_i;
        end
      end
    end
    if (data_v_i && data_yumi_o) begin
      if (data_op_i == e_data_write) begin
        data_mem[data_index_i][data_way_i] <= data_wdata_i;
        dirty_mem[data_index_i][data_way_i] <= 1'b1;
      end else begin
        data_rdata_o <= data_mem[data_index_i][data_way_i];
      end
    end
    if (stat_v_i && stat_yumi_o) begin
      case (stat_op_i)
        e_stat_set_clear: dirty_mem[stat_index_i] <= '0;
        e_stat_read: stat_dirty_o <= dirty_mem[stat_index_i];
        default: dirty_mem[stat_index_i][stat_way_i] <= 1'b0;
      endcase
    end
    if (tag_v_i && tag_yumi_o && tag_op_i == e_tag_set_clear
        && stat_v_i && stat_yumi_o && stat_op_i == e_stat_set_clear
        && tag_index_i == stat_index_i) begin
      cleared[tag_index_i] <= 1'b1;
    end
  end

endmodule

//--- hw/lce_cmd_top.sv
module lce_cmd_top #(
  parameter int sets_p    = 64,
  parameter int num_cce_p = 2
) (
  input  logic clk_i,
  input  logic reset_i,
  input  lce_pkg::lce_id_t    lce_id_i,
  output logic                ready_o,
  input  logic                cmd_v_i,
  input  lce_pkg::lce_cmd_e   cmd_type_i,
  input  lce_pkg::paddr_t     cmd_addr_i,
  input  lce_pkg::lce_id_t    cmd_src_id_i,
  input  lce_pkg::way_t       cmd_way_i,
  input  lce_pkg::coh_state_e cmd_state_i,
  input  lce_pkg::block_t     cmd_data_i,
  output logic                cmd_yumi_o,
  output logic                resp_v_o,
  output lce_pkg::lce_resp_e  resp_type_o,
  output lce_pkg::paddr_t     resp_addr_o,
  output lce_pkg::lce_id_t    resp_dst_id_o,
  output lce_pkg::lce_id_t    resp_src_id_o,
  output lce_pkg::block_t     resp_data_o,
  input  logic                resp_yumi_i,
  output logic                tag_v_o,
  output lce_pkg::tag_op_e    tag_op_o,
  output lce_pkg::index_t     tag_index_o,
  output lce_pkg::way_t       tag_way_o,
  output lce_pkg::coh_state_e tag_state_o,
  output lce_pkg::tag_t       tag_tag_o,
  input  logic                tag_yumi_i,
  output logic                data_v_o,
  output lce_pkg::data_op_e   data_op_o,
  output lce_pkg::index_t     data_index_o,
  output lce_pkg::way_t       data_way_o,
  output lce_pkg::block_t     data_wdata_o,
  input  logic                data_yumi_i,
  input  lce_pkg::block_t     data_rdata_i,
  output logic                stat_v_o,
  output lce_pkg::stat_op_e   stat_op_o,
  output lce_pkg::index_t     stat_index_o,
  output lce_pkg::way_t       stat_way_o,
  input  logic                stat_yumi_i,
  input  lce_pkg::dirty_vec_t stat_dirty_i,
  output logic                cache_req_complete_o,
  output logic                sync_done_o
);
  import lce_pkg::*;

  index_t     index;
  tag_t       tag;
  tag_op_e    tag_op;
  logic       do_tag_write, do_stat_read, do_data_write, do_coh_ack, do_inv_ack;
  block_t     block_held;
  dirty_vec_t stat_held;
  logic       block_held_v, stat_held_v;
  logic       data_read_accept, stat_read_accept;

  lce_cmd_decode decode0 (
    .clk_i, .cmd_v_i, .cmd_type_i, .cmd_addr_i, .cmd_state_i,
    .index_o(index), .tag_o(tag), .do_tag_write_o(do_tag_write), .tag_op_o(tag_op),
    .do_stat_read_o(do_stat_read), .do_data_write_o(do_data_write),
    .do_coh_ack_o(do_coh_ack), .do_inv_ack_o(do_inv_ack)
  );

  lce_cmd_ctrl #(.sets_p(sets_p), .num_cce_p(num_cce_p)) ctrl0 (
    .clk_i, .reset_i, .lce_id_i,
    .index_i(index), .tag_i(tag), .do_tag_write_i(do_tag_write), .tag_op_i(tag_op),
    .do_stat_read_i(do_stat_read), .do_data_write_i(do_data_write),
    .do_coh_ack_i(do_coh_ack), .do_inv_ack_i(do_inv_ack),
    .cmd_v_i, .cmd_type_i, .cmd_src_id_i, .cmd_way_i, .cmd_state_i, .cmd_addr_i,
    .cmd_data_i, .cmd_yumi_o,
    .tag_v_o, .tag_op_o, .tag_index_o, .tag_way_o, .tag_state_o, .tag_tag_o, .tag_yumi_i,
    .data_v_o, .data_op_o, .data_index_o, .data_way_o, .data_wdata_o, .data_yumi_i,
    .stat_v_o, .stat_op_o, .stat_index_o, .stat_way_o, .stat_yumi_i,
    .block_held_i(block_held), .block_held_v_i(block_held_v),
    .stat_held_i(stat_held), .stat_held_v_i(stat_held_v),
    .data_read_accept_o(data_read_accept), .stat_read_accept_o(stat_read_accept),
    .resp_v_o, .resp_type_o, .resp_addr_o, .resp_dst_id_o, .resp_src_id_o, .resp_data_o,
    .resp_yumi_i, .ready_o, .sync_done_o, .cache_req_complete_o
  );

  // block capture for dirty writebacks
  lce_read_capture #(.width_p(block_width_gp)) block_capture0 (
    .clk_i, .reset_i, .read_accept_i(data_read_accept), .rdata_i(data_rdata_i),
    .held_o(block_held), .held_v_o(block_held_v)
  );

  // dirty bits of the set, read before each writeback
  lce_read_capture #(.width_p(ways_gp)) stat_capture0 (
    .clk_i, .reset_i, .read_accept_i(stat_read_accept), .rdata_i(stat_dirty_i),
    .held_o(stat_held), .held_v_o(stat_held_v)
  );

endmodule

//--- hw/lce_cmd_ctrl.sv
module lce_cmd_ctrl #(
  parameter int sets_p    = 64,
  parameter int num_cce_p = 2
) (
  input  logic clk_i,
  input  logic reset_i,
  input  lce_pkg::lce_id_t    lce_id_i,
  input  lce_pkg::index_t     index_i,
  input  lce_pkg::tag_t       tag_i,
  input  logic                do_tag_write_i,
  input  lce_pkg::tag_op_e    tag_op_i,
  input  logic                do_stat_read_i,
  input  logic                do_data_write_i,
  input  logic                do_coh_ack_i,
  input  logic                do_inv_ack_i,
  input  logic                cmd_v_i,
  input  lce_pkg::lce_cmd_e   cmd_type_i,
  input  lce_pkg::lce_id_t    cmd_src_id_i,
  input  lce_pkg::way_t       cmd_way_i,
  input  lce_pkg::coh_state_e cmd_state_i,
  input  lce_pkg::paddr_t     cmd_addr_i,
  input  lce_pkg::block_t     cmd_data_i,
  output logic                cmd_yumi_o,
  output logic                tag_v_o,
  output lce_pkg::tag_op_e    tag_op_o,
  output lce_pkg::index_t     tag_index_o,
  output lce_pkg::way_t       tag_way_o,
  output lce_pkg::coh_state_e tag_state_o,
  output lce_pkg::tag_t       tag_tag_o,
  input  logic                tag_yumi_i,
  output logic                data_v_o,
  output lce_pkg::data_op_e   data_op_o,
  output lce_pkg::index_t     data_index_o,
  output lce_pkg::way_t       data_way_o,
  output lce_pkg::block_t     data_wdata_o,
  input  logic                data_yumi_i,
  output logic                stat_v_o,
  output lce_pkg::stat_op_e   stat_op_o,
  output lce_pkg::index_t     stat_index_o,
  output lce_pkg::way_t       stat_way_o,
  input  logic                stat_yumi_i,
  input  lce_pkg::block_t     block_held_i,
  input  logic                block_held_v_i,
  input  lce_pkg::dirty_vec_t stat_held_i,
  input  logic                stat_held_v_i,
  output logic                data_read_accept_o,
  output logic                stat_read_accept_o,
  output logic                resp_v_o,
  output lce_pkg::lce_resp_e  resp_type_o,
  output lce_pkg::paddr_t     resp_addr_o,
  output lce_pkg::lce_id_t    resp_dst_id_o,
  output lce_pkg::lce_id_t    resp_src_id_o,
  output lce_pkg::block_t     resp_data_o,
  input  logic                resp_yumi_i,
  output logic                ready_o,
  output logic                sync_done_o,
  output logic                cache_req_complete_o
);
  import lce_pkg::*;

  localparam int cnt_width_lp = $clog2((sets_p > num_cce_p ? sets_p : num_cce_p) + 1);

  typedef enum logic [2:0] {
    e_reset, e_clear, e_ready, e_coh_ack, e_wb_stat_rd, e_wb, e_wb_dirty_rd, e_wb_dirty_send
  } ctrl_state_e;

  ctrl_state_e state_r, state_n;
  logic [cnt_width_lp-1:0] cnt_r;
  logic cnt_inc, cnt_clr;
  logic sync_done_r, sync_set;
  logic inv_done_r, inv_done_set;
  logic fill_accept, wb_dirty, wb_clean;

  // tag write plus the data write when the command carries a block
  assign fill_accept = tag_yumi_i & (data_yumi_i | ~do_data_write_i);
  assign wb_dirty    = stat_held_v_i & stat_held_i[cmd_way_i];
  assign wb_clean    = stat_held_v_i & ~stat_held_i[cmd_way_i];

  assign data_index_o  = index_i;
  assign data_way_o    = cmd_way_i;
  assign data_wdata_o  = cmd_data_i;
  assign stat_way_o    = cmd_way_i;
  assign resp_addr_o   = cmd_addr_i;
  assign resp_dst_id_o = cmd_src_id_i;
  assign resp_src_id_o = lce_id_i;
  assign ready_o       = (state_r != e_reset) && (state_r != e_clear);
  assign sync_done_o   = sync_done_r;

  assign data_read_accept_o = data_v_o & data_yumi_i & (data_op_o == e_data_read);
  assign stat_read_accept_o = stat_v_o & stat_yumi_i & (stat_op_o == e_stat_read);

  always_comb begin
    state_n = state_r;
    cnt_inc = 1'b0;
    cnt_clr = 1'b0;
    sync_set = 1'b0;
    inv_done_set = 1'b0;
    cmd_yumi_o = 1'b0;
    cache_req_complete_o = 1'b0;
    tag_v_o = 1'b0;
    tag_op_o = tag_op_i;
    tag_index_o = index_i;
    tag_way_o = cmd_way_i;
    tag_state_o = cmd_state_i;
    tag_tag_o = (tag_op_i == e_tag_set_tag) ? tag_i : '0;
    data_v_o = 1'b0;
    data_op_o = e_data_read;
    stat_v_o = 1'b0;
    stat_op_o = e_stat_read;
    stat_index_o = index_i;
    resp_v_o = 1'b0;
    resp_type_o = e_resp_sync_ack;
    resp_data_o = '0;
    unique case (state_r)
      e_reset: state_n = e_clear;
      // one set per accepted tag and status pair
      e_clear: begin
        tag_v_o = 1'b1;
        tag_op_o = e_tag_set_clear;
        tag_index_o = index_t'(cnt_r);
        tag_state_o = e_coh_i;
        tag_tag_o = '0;
        stat_v_o = 1'b1;
        stat_op_o = e_stat_set_clear;
        stat_index_o = index_t'(cnt_r);
        if (tag_yumi_i && stat_yumi_i) begin
          if (cnt_r == cnt_width_lp'(sets_p - 1)) begin
            cnt_clr = 1'b1;
            state_n = e_ready;
          end else begin
            cnt_inc = 1'b1;
          end
        end
      end
      e_ready: begin
        if (cmd_v_i) begin
          if (cmd_type_i == e_cmd_sync) begin
            resp_v_o = 1'b1;
            cmd_yumi_o = resp_yumi_i;
            // the counter now counts acknowledged syncs
            if (resp_yumi_i && cnt_r == cnt_width_lp'(num_cce_p - 1)) begin
              cnt_clr = 1'b1;
              sync_set = 1'b1;
            end else begin
              cnt_inc = resp_yumi_i;
            end
          end else if (do_stat_read_i) begin
            if (do_tag_write_i) begin
              tag_v_o = 1'b1;
              state_n = tag_yumi_i ? e_wb_stat_rd : e_ready;
            end else begin
              stat_v_o = 1'b1;
              state_n = stat_yumi_i ? e_wb : e_ready;
            end
          end else if (do_tag_write_i && tag_op_i == e_tag_set_clear) begin
            tag_v_o = 1'b1;
            tag_state_o = e_coh_i;
            stat_v_o = 1'b1;
            stat_op_o = e_stat_set_clear;
            cmd_yumi_o = tag_yumi_i & stat_yumi_i;
          end else if (do_inv_ack_i) begin
            // ack goes out once the invalidate has reached the tag memory
            tag_v_o = ~inv_done_r;
            tag_state_o = e_coh_i;
            inv_done_set = tag_yumi_i;
            resp_v_o = inv_done_r | tag_yumi_i;
            resp_type_o = e_resp_inv_ack;
            cmd_yumi_o = (inv_done_r | tag_yumi_i) & resp_yumi_i;
          end else if (do_tag_write_i) begin
            tag_v_o = 1'b1;
            data_v_o = do_data_write_i;
            data_op_o = e_data_write;
            if (do_coh_ack_i) begin
              state_n = fill_accept ? e_coh_ack : e_ready;
            end else begin
              cmd_yumi_o = fill_accept;
            end
          end
        end
      end
      e_coh_ack: begin
        resp_v_o = cmd_v_i;
        resp_type_o = e_resp_coh_ack;
        cmd_yumi_o = resp_yumi_i;
        cache_req_complete_o = resp_yumi_i;
        state_n = resp_yumi_i ? e_ready : e_coh_ack;
      end
      e_wb_stat_rd: begin
        stat_v_o = 1'b1;
        state_n = stat_yumi_i ? e_wb : e_wb_stat_rd;
      end
      // clean line answers with a null writeback
      e_wb: begin
        resp_v_o = wb_clean;
        resp_type_o = e_resp_null_wb;
        cmd_yumi_o = wb_clean & resp_yumi_i;
        if (wb_dirty) begin
          state_n = e_wb_dirty_rd;
        end else if (wb_clean && resp_yumi_i) begin
          state_n = e_ready;
        end
      end
      e_wb_dirty_rd: begin
        data_v_o = 1'b1;
        stat_v_o = 1'b1;
        stat_op_o = e_stat_clear_dirty;
        state_n = (data_yumi_i && stat_yumi_i) ? e_wb_dirty_send : e_wb_dirty_rd;
      end
      e_wb_dirty_send: begin
        resp_v_o = block_held_v_i;
        resp_type_o = e_resp_wb;
        resp_data_o = block_held_i;
        cmd_yumi_o = block_held_v_i & resp_yumi_i;
        state_n = (block_held_v_i && resp_yumi_i) ? e_ready : e_wb_dirty_send;
      end
      default: state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
      cnt_r <= '0;
      sync_done_r <= 1'b0;
      inv_done_r <= 1'b0;
    end else begin
      state_r <= state_n;
      if (cnt_clr) begin
        cnt_r <= '0;
      end else if (cnt_inc) begin
        cnt_r <= cnt_r + 1'b1;
      end
      if (sync_set) begin
        sync_done_r <= 1'b1;
      end
      if (cmd_yumi_o) begin
        inv_done_r <= 1'b0;
      end else if (inv_done_set) begin
        inv_done_r <= 1'b1;
      end
    end
  end

  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_yumi_o |-> cmd_v_i);

  a_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && !resp_yumi_i |=> resp_v_o && $stable(resp_type_o) && $stable(resp_addr_o)
                                  && $stable(resp_dst_id_o) && $stable(resp_data_o));

endmodule

//--- hw/lce_read_capture.sv
module lce_read_capture #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               read_accept_i,
  input  logic [width_p-1:0] rdata_i,
  output logic [width_p-1:0] held_o,
  output logic               held_v_o
);

  logic accept_r;
  logic held_v_r;
  logic [width_p-1:0] held_r;

  // read data shows up on rdata_i the cycle after the accept
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      accept_r <= 1'b0;
    end else begin
      accept_r <= read_accept_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_r) begin
      held_r <= rdata_i;
    end
  end

  // a new accept drops the flag so stale data is never seen as valid
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      held_v_r <= 1'b0;
    end else if (read_accept_i) begin
      held_v_r <= 1'b0;
    end else if (accept_r) begin
      held_v_r <= 1'b1;
    end
  end

  assign held_o   = held_r;
  assign held_v_o = held_v_r;

  // the memory has to answer an accepted read in the following cycle
  a_capture_after_accept: assert property (@(posedge clk_i) disable iff (reset_i)
    accept_r |-> !$isunknown(rdata_i));

endmodule

//--- hw/lce_cmd_decode.sv
module lce_cmd_decode (
  input  logic                clk_i,
  input  logic                cmd_v_i,
  input  lce_pkg::lce_cmd_e   cmd_type_i,
  input  lce_pkg::paddr_t     cmd_addr_i,
  input  lce_pkg::coh_state_e cmd_state_i,
  output lce_pkg::index_t     index_o,
  output lce_pkg::tag_t       tag_o,
  output logic                do_tag_write_o,
  output lce_pkg::tag_op_e    tag_op_o,
  output logic                do_stat_read_o,
  output logic                do_data_write_o,
  output logic                do_coh_ack_o,
  output logic                do_inv_ack_o
);
  import lce_pkg::*;

  assign index_o = cmd_addr_i[offset_width_gp +: index_width_gp];
  assign tag_o   = cmd_addr_i[paddr_width_gp-1 -: tag_width_gp];

  // sync leaves every action flag low
  always_comb begin
    do_tag_write_o  = 1'b0;
    tag_op_o        = e_tag_set_state;
    do_stat_read_o  = 1'b0;
    do_data_write_o = 1'b0;
    do_coh_ack_o    = 1'b0;
    do_inv_ack_o    = 1'b0;
    unique case (cmd_type_i)
      e_cmd_set_clear: begin
        do_tag_write_o = 1'b1;
        tag_op_o       = e_tag_set_clear;
      end
      e_cmd_inv: begin
        do_tag_write_o = 1'b1;
        do_inv_ack_o   = 1'b1;
      end
      e_cmd_st: do_tag_write_o = 1'b1;
      e_cmd_data: begin
        do_tag_write_o  = 1'b1;
        tag_op_o        = e_tag_set_tag;
        do_data_write_o = 1'b1;
        do_coh_ack_o    = 1'b1;
      end
      e_cmd_st_wakeup: begin
        do_tag_write_o = 1'b1;
        do_coh_ack_o   = 1'b1;
      end
      e_cmd_wb: do_stat_read_o = 1'b1;
      e_cmd_st_wb: begin
        do_tag_write_o = 1'b1;
        do_stat_read_o = 1'b1;
      end
      default: ;
    endcase
  end

  a_known_cmd: assert property (@(posedge clk_i)
    cmd_v_i |-> cmd_type_i inside {e_cmd_sync, e_cmd_set_clear, e_cmd_inv, e_cmd_st,
                                   e_cmd_data, e_cmd_st_wakeup, e_cmd_wb, e_cmd_st_wb});

  // the commanded state lands in the tag memory and has to be a real state
  a_known_state: assert property (@(posedge clk_i)
    cmd_v_i && do_tag_write_o && tag_op_o != e_tag_set_clear && !do_inv_ack_o
    |-> cmd_state_i inside {e_coh_i, e_coh_s, e_coh_e, e_coh_m, e_coh_o, e_coh_f});

endmodule

//--- hw/lce_pkg.sv
package lce_pkg;

  // the address splits into block offset, set index and tag
  localparam int paddr_width_gp  = 40;
  localparam int offset_width_gp = 6;
  localparam int index_width_gp  = 6;
  localparam int tag_width_gp    = paddr_width_gp - index_width_gp - offset_width_gp;

  localparam int ways_gp         = 8;
  localparam int way_width_gp    = 3;
  localparam int block_width_gp  = 512;
  localparam int lce_id_width_gp = 4;

  typedef logic [paddr_width_gp-1:0]  paddr_t;
  typedef logic [index_width_gp-1:0]  index_t;
  typedef logic [tag_width_gp-1:0]    tag_t;
  typedef logic [way_width_gp-1:0]    way_t;
  typedef logic [ways_gp-1:0]         dirty_vec_t;
  typedef logic [block_width_gp-1:0]  block_t;
  typedef logic [lce_id_width_gp-1:0] lce_id_t;

  typedef enum logic [2:0] {
    e_coh_i, e_coh_s, e_coh_e, e_coh_m, e_coh_o, e_coh_f
  } coh_state_e;

  // commands from the directory
  typedef enum logic [3:0] {
    e_cmd_sync, e_cmd_set_clear, e_cmd_inv, e_cmd_st,
    e_cmd_data, e_cmd_st_wakeup, e_cmd_wb, e_cmd_st_wb
  } lce_cmd_e;

  typedef enum logic [2:0] {
    e_resp_sync_ack, e_resp_inv_ack, e_resp_coh_ack, e_resp_wb, e_resp_null_wb
  } lce_resp_e;

  // cache memory port opcodes
  typedef enum logic [1:0] {e_tag_set_clear, e_tag_set_state, e_tag_set_tag} tag_op_e;
  typedef enum logic {e_data_read, e_data_write} data_op_e;
  typedef enum logic [1:0] {e_stat_set_clear, e_stat_read, e_stat_clear_dirty} stat_op_e;

endpackage
